// ==== src/fetch_queue_macros.svh ====
`ifndef FETCH_QUEUE_MACROS_SVH
`define FETCH_QUEUE_MACROS_SVH

// bits per instruction word
`define FQ_INSTR_WIDTH 32

// decoders fed per cycle, also the words per fetch bundle
`define FQ_DECODERS 4

// queue index width, depth is 2**FQ_INDEX_BITS
`define FQ_INDEX_BITS 4

// number of instruction slots in the queue
`define FQ_DEPTH (1 << `FQ_INDEX_BITS)

`endif

// ==== src/fetch_queue_pkg.sv ====
`include "fetch_queue_macros.svh"

package fetch_queue_pkg;

    // one instruction word
    typedef logic [`FQ_INSTR_WIDTH-1:0] instr_t;

    // a fetch bundle, element 0 is the oldest word
    typedef instr_t [`FQ_DECODERS-1:0] bundle_t;

    // slot index into the queue array
    typedef logic [`FQ_INDEX_BITS-1:0] qidx_t;

    // occupancy from 0 up to and including FQ_DEPTH
    typedef logic [`FQ_INDEX_BITS:0] qcount_t;

    // one bit per decoder, bit 0 is decoder 1
    typedef logic [`FQ_DECODERS-1:0] dec_mask_t;

    // instructions issued in one cycle, 0 to 4
    typedef logic [2:0] pop_t;

endpackage

// ==== src/queue_read_if.sv ====
`timescale 1ns/100ps
`include "fetch_queue_macros.svh"

interface queue_read_if;

    fetch_queue_pkg::qidx_t   head;    // oldest valid slot
    fetch_queue_pkg::qcount_t count;   // words currently held
    fetch_queue_pkg::bundle_t window;  // slots head .. head+3
    fetch_queue_pkg::pop_t    pop;     // words issued this cycle

    modport pointers (
        output head,
        output count,
        input  pop
    );

    modport storage (
        input  head,
        output window
    );

    modport dispatch (
        input  count,
        input  window,
        output pop
    );

endinterface

// ==== src/queue_storage.sv ====
`timescale 1ns/100ps
`include "fetch_queue_macros.svh"

module queue_storage (
    input  logic                     clock_i,
    input  logic                     write_i,
    input  fetch_queue_pkg::qidx_t   tail_i,
    input  fetch_queue_pkg::bundle_t bundle_i,
    queue_read_if.storage            rd
);

    fetch_queue_pkg::instr_t instr_mem [`FQ_DEPTH];  // circular instruction store

    // bundle lands in four consecutive slots starting at the tail
    always_ff @(posedge clock_i)
    begin
        if (write_i)
        begin
            for (int w = 0; w < `FQ_DECODERS; w++)
            begin
                instr_mem[tail_i + fetch_queue_pkg::qidx_t'(w)] <= bundle_i[w];  // index wraps
            end
        end
    end

    // read window at the head, the dispatcher decides how much of it is valid
    always_comb
    begin
        for (int k = 0; k < `FQ_DECODERS; k++)
        begin
            rd.window[k] = instr_mem[rd.head + fetch_queue_pkg::qidx_t'(k)];  // wraps at depth
        end
    end

endmodule

// ==== src/queue_pointers.sv ====
`timescale 1ns/100ps
`include "fetch_queue_macros.svh"

module queue_pointers (
    input  logic                   clock_i,
    input  logic                   reset_i,
    input  logic                   bundle_write_i,
    output logic                   accept_o,
    output fetch_queue_pkg::qidx_t tail_o,
    output fetch_queue_pkg::qidx_t head_o,
    output logic                   full_o,
    output logic                   empty_o,
    queue_read_if.pointers         rd
);

    // highest count at which a whole bundle still fits
    localparam fetch_queue_pkg::qcount_t space_limit =
        fetch_queue_pkg::qcount_t'(`FQ_DEPTH - `FQ_DECODERS);

    fetch_queue_pkg::qidx_t   head_q;
    fetch_queue_pkg::qidx_t   tail_q;
    fetch_queue_pkg::qcount_t count_q;
    fetch_queue_pkg::qcount_t push_n;   // words added this cycle
    fetch_queue_pkg::qcount_t pop_n;    // words removed this cycle

    // a refused bundle is simply dropped
    assign accept_o = bundle_write_i && (count_q <= space_limit);

    assign push_n = accept_o ? fetch_queue_pkg::qcount_t'(`FQ_DECODERS) : '0;
    assign pop_n  = fetch_queue_pkg::qcount_t'(rd.pop);

    always_ff @(posedge clock_i)
    begin
        if (reset_i)
        begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (accept_o)
            begin
                tail_q <= tail_q + fetch_queue_pkg::qidx_t'(`FQ_DECODERS);  // wraps at depth
            end
            head_q  <= head_q + fetch_queue_pkg::qidx_t'(rd.pop);
            count_q <= count_q + push_n - pop_n;  // pop never exceeds old count
        end
    end

    // pointer view for the rest of the queue
    assign rd.head  = head_q;
    assign rd.count = count_q;

    assign head_o = head_q;
    assign tail_o = tail_q;

    // flags follow the count register directly
    assign full_o  = count_q > space_limit;  // no room for another bundle
    assign empty_o = count_q == '0;

endmodule

// ==== src/dispatch_steer.sv ====
`timescale 1ns/100ps
`include "fetch_queue_macros.svh"

module dispatch_steer (
    input  logic                       clock_i,
    input  logic                       reset_i,
    input  fetch_queue_pkg::dec_mask_t busy_i,
    output fetch_queue_pkg::dec_mask_t dec_en_o,
    output fetch_queue_pkg::bundle_t   dec_instr_o,
    queue_read_if.dispatch             rd
);

    fetch_queue_pkg::dec_mask_t ready;   // decoders able to take a word
    fetch_queue_pkg::dec_mask_t grant;   // decoders served this cycle
    fetch_queue_pkg::bundle_t   picked;  // word steered to each decoder
    fetch_queue_pkg::pop_t      taken;   // running count of grants

    assign ready = ~busy_i;

    // Walk the decoders from 1 to 4. Each ready decoder takes the next
    // unissued window slot until the queue runs out of words.
    always_comb
    begin
        taken  = '0;
        grant  = '0;
        picked = dec_instr_o;  // ungranted lanes keep their word
        for (int d = 0; d < `FQ_DECODERS; d++)
        begin
            if (ready[d] && (fetch_queue_pkg::qcount_t'(taken) < rd.count))
            begin
                grant[d]  = 1'b1;
                picked[d] = rd.window[taken];  // slot k goes to k-th ready decoder
                taken     = taken + 3'd1;
            end
        end
    end

    assign rd.pop = taken;  // head advances by the grant count

    // enables are single-cycle pulses
    always_ff @(posedge clock_i)
    begin
        if (reset_i)
        begin
            dec_en_o <= '0;
        end
        else
        begin
            dec_en_o <= grant;
        end
    end

    // instruction words hold when a decoder gets nothing
    always_ff @(posedge clock_i)
    begin
        for (int d = 0; d < `FQ_DECODERS; d++)
        begin
            if (grant[d])
            begin
                dec_instr_o[d] <= picked[d];
            end
        end
    end

endmodule

// ==== src/fetch_queue.sv ====
`timescale 1ns/100ps
`include "fetch_queue_macros.svh"

module fetch_queue (
    input  logic                       clock_i,
    input  logic                       reset_i,

    // fetch side
    input  logic                       bundle_write_i,
    input  fetch_queue_pkg::bundle_t   bundle_i,

    // decoder side
    input  fetch_queue_pkg::dec_mask_t decode_busy_i,
    output fetch_queue_pkg::dec_mask_t decoder_en_o,
    output fetch_queue_pkg::instr_t    decoder1_instr_o,
    output fetch_queue_pkg::instr_t    decoder2_instr_o,
    output fetch_queue_pkg::instr_t    decoder3_instr_o,
    output fetch_queue_pkg::instr_t    decoder4_instr_o,

    // queue state
    output fetch_queue_pkg::qidx_t     head_o,
    output fetch_queue_pkg::qidx_t     tail_o,
    output logic                       is_full_o,
    output logic                       is_empty_o
);

    logic                     bundle_accept;  // bundle fits, write it this edge
    fetch_queue_pkg::bundle_t dec_instr;      // registered words, one per decoder

    queue_read_if rd_if ();

    queue_pointers u_pointers (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .bundle_write_i (bundle_write_i),
        .accept_o       (bundle_accept),
        .tail_o         (tail_o),
        .head_o         (head_o),
        .full_o         (is_full_o),
        .empty_o        (is_empty_o),
        .rd             (rd_if.pointers)
    );

    queue_storage u_storage (
        .clock_i  (clock_i),
        .write_i  (bundle_accept),
        .tail_i   (tail_o),    // write position is the registered tail
        .bundle_i (bundle_i),
        .rd       (rd_if.storage)
    );

    dispatch_steer u_dispatch (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .busy_i      (decode_busy_i),
        .dec_en_o    (decoder_en_o),
        .dec_instr_o (dec_instr),
        .rd          (rd_if.dispatch)
    );

    // lane 0 feeds decoder 1
    assign decoder1_instr_o = dec_instr[0];
    assign decoder2_instr_o = dec_instr[1];
    assign decoder3_instr_o = dec_instr[2];
    assign decoder4_instr_o = dec_instr[3];

endmodule

// ==== testbench/fetch_queue_tb.sv ====
`timescale 1ns/100ps
`include "fetch_queue_macros.svh"

module fetch_queue_tb;

    localparam int free_limit = `FQ_DEPTH - `FQ_DECODERS;  // highest count that takes a bundle

    logic                       clock_i;
    logic                       reset_i;
    logic                       bundle_write_i;
    fetch_queue_pkg::bundle_t   bundle_i;
    fetch_queue_pkg::dec_mask_t decode_busy_i;
    fetch_queue_pkg::dec_mask_t decoder_en_o;
    fetch_queue_pkg::instr_t    dec1_instr;
    fetch_queue_pkg::instr_t    dec2_instr;
    fetch_queue_pkg::instr_t    dec3_instr;
    fetch_queue_pkg::instr_t    dec4_instr;
    fetch_queue_pkg::qidx_t     head_o;
    fetch_queue_pkg::qidx_t     tail_o;
    logic                       is_full_o;
    logic                       is_empty_o;

    // stimulus lines, one entry per cycle
    bit                         ln_write [$];
    fetch_queue_pkg::instr_t    ln_word [$];   // four per line, oldest first
    fetch_queue_pkg::dec_mask_t ln_busy [$];
    fetch_queue_pkg::dec_mask_t ln_en [$];
    bit                         ln_full [$];
    bit                         ln_empty [$];
    int                         ln_test [$];
    string                      test_name [$];
    int                         test_err [$];

    fetch_queue_pkg::instr_t    model_q [$];   // every accepted word in program order
    fetch_queue_pkg::qidx_t     model_head = '0;
    fetch_queue_pkg::qidx_t     model_tail = '0;
    bit                         pend_accept = 1'b0;  // bundle of the line in flight fits
    fetch_queue_pkg::instr_t    held_word [`FQ_DECODERS];  // last word each decoder received

    int check_count = 0;
    int error_count = 0;
    int cur_test = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    fetch_queue dut (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .bundle_write_i   (bundle_write_i),
        .bundle_i         (bundle_i),
        .decode_busy_i    (decode_busy_i),
        .decoder_en_o     (decoder_en_o),
        .decoder1_instr_o (dec1_instr),
        .decoder2_instr_o (dec2_instr),
        .decoder3_instr_o (dec3_instr),
        .decoder4_instr_o (dec4_instr),
        .head_o           (head_o),
        .tail_o           (tail_o),
        .is_full_o        (is_full_o),
        .is_empty_o       (is_empty_o)
    );

    initial
    begin
        clock_i = 1'b0;
        forever #4 clock_i = ~clock_i;
    end

    // run limit follows the number of stimulus lines
    always @(posedge clock_i)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    function automatic fetch_queue_pkg::instr_t word_of(input int d);
        case (d)
            0:       return dec1_instr;
            1:       return dec2_instr;
            2:       return dec3_instr;
            default: return dec4_instr;
        endcase
    endfunction

    function automatic string trim_line(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r.getc(r.len() - 1) == 8'h0a || r.getc(r.len() - 1) == 8'h0d
               || r.getc(r.len() - 1) == 8'h20))
        begin
            r = r.substr(0, r.len() - 2);
        end
        return r;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count = check_count + 1;
        if (actual !== expected)
        begin
            $display("ERR time %0t signal %s expected %h actual %h", $time, sig, expected, actual);
            error_count = error_count + 1;
            test_err[cur_test] = test_err[cur_test] + 1;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s at time %0t", what, $time);
        error_count = error_count + 1;
        test_err[cur_test] = test_err[cur_test] + 1;
    endtask

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          got;
        string       line;
        logic [31:0] f_w, f_i0, f_i1, f_i2, f_i3, f_busy, f_en, f_full, f_empty;
        ok = 1'b1;
        fd = $fopen("testbench/fetch_queue_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file");
            ok = 1'b0;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                got  = $fgets(line, fd);
                line = trim_line(line);
                if (got != 0 && line.len() != 0 && line.getc(0) != "#")
                begin
                    if (line.len() > 5 && line.substr(0, 4) == "test ")
                    begin
                        test_name.push_back(line.substr(5, line.len() - 1));
                        test_err.push_back(0);
                    end
                    else
                    begin
                        got = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_w, f_i0, f_i1,
                                      f_i2, f_i3, f_busy, f_en, f_full, f_empty);
                        if (got != 9 || test_name.size() == 0)
                        begin
                            $display("stimulus line could not be read: %s", line);
                            ok = 1'b0;
                        end
                        else
                        begin
                            ln_write.push_back(f_w[0]);
                            ln_word.push_back(f_i0);
                            ln_word.push_back(f_i1);
                            ln_word.push_back(f_i2);
                            ln_word.push_back(f_i3);
                            ln_busy.push_back(f_busy[3:0]);
                            ln_en.push_back(f_en[3:0]);
                            ln_full.push_back(f_full[0]);
                            ln_empty.push_back(f_empty[0]);
                            ln_test.push_back(test_name.size() - 1);
                        end
                    end
                end
            end
            $fclose(fd);
            if (ln_test.size() == 0)
            begin
                $display("the stimulus file holds no cycle lines");
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_reset_state();
        check_value("is_empty_o", 1'b1, is_empty_o);
        check_value("is_full_o", 1'b0, is_full_o);
        check_value("decoder_en_o", '0, decoder_en_o);
        check_value("head_o", '0, head_o);
        check_value("tail_o", '0, tail_o);
    endtask

    // drive one line at the falling edge
    task automatic apply_line(input int i);
        bundle_write_i = ln_write[i];
        for (int w = 0; w < `FQ_DECODERS; w++)
        begin
            if (ln_write[i])
            begin
                bundle_i[w] = ln_word[4 * i + w];
            end
            else
            begin
                bundle_i[w] = $urandom();  // don't care when not writing
            end
        end
        decode_busy_i = ln_busy[i];
        pend_accept   = ln_write[i] && (model_q.size() <= free_limit);
    endtask

    // responses to line i, one falling edge after it was driven
    task automatic check_line(input int i);
        fetch_queue_pkg::instr_t expected_word;
        cur_test = ln_test[i];
        check_value("decoder_en_o", ln_en[i], decoder_en_o);
        for (int d = 0; d < `FQ_DECODERS; d++)
        begin
            if (decoder_en_o[d] === 1'b1)
            begin
                if (model_q.size() == 0)
                begin
                    report_failure($sformatf("decoder %0d got a word the queue never held", d + 1));
                end
                else
                begin
                    expected_word = model_q.pop_front();
                    check_value($sformatf("decoder%0d_instr_o", d + 1), expected_word, word_of(d));
                    held_word[d] = expected_word;
                    model_head = model_head + 1'b1;
                end
            end
            else
            begin
                // an idle decoder keeps the word it last received
                check_value($sformatf("decoder%0d_instr_o", d + 1), held_word[d], word_of(d));
            end
        end
        if (pend_accept)
        begin
            for (int w = 0; w < `FQ_DECODERS; w++)
            begin
                model_q.push_back(ln_word[4 * i + w]);
            end
            model_tail = model_tail + 4'd4;  // wraps at depth
        end
        check_value("head_o", model_head, head_o);
        check_value("tail_o", model_tail, tail_o);
        check_value("is_full_o", ln_full[i], is_full_o);
        check_value("is_empty_o", ln_empty[i], is_empty_o);
    endtask

    task automatic report_test(input int t);
        $display("[%0d] %s: %s, %0d errors", t + 1, test_name[t],
                 (test_err[t] == 0) ? "ok" : "FAIL", test_err[t]);
    endtask

    task automatic close_line(input int i);
        check_line(i);
        if (i == ln_test.size() - 1 || ln_test[i + 1] != ln_test[i])
        begin
            report_test(ln_test[i]);
        end
    endtask

    initial
    begin
        bit loaded;
        int failed_tests;
        reset_i        = 1'b1;
        bundle_write_i = 1'b0;
        bundle_i       = '0;
        decode_busy_i  = '0;
        failed_tests   = 0;
        void'($urandom(32'hf282));
        load_stimulus(loaded);
        if (!loaded)
        begin
            $display("test failed");
            $finish;
        end
        else
        begin
            cycle_limit = 2 * ln_test.size() + 20;
            repeat (5) @(posedge clock_i);
            @(negedge clock_i);
            reset_i  = 1'b0;
            cur_test = 0;
            check_reset_state();
            for (int i = 0; i < ln_test.size(); i++)
            begin
                if (i > 0)
                begin
                    @(negedge clock_i);
                    close_line(i - 1);
                end
                apply_line(i);
            end
            @(negedge clock_i);
            close_line(ln_test.size() - 1);
            for (int t = 0; t < test_err.size(); t++)
            begin
                if (test_err[t] != 0)
                begin
                    failed_tests = failed_tests + 1;
                end
            end
            $display("%0d tests, %0d failed, %0d checks, %0d errors", test_err.size(),
                     failed_tests, check_count, error_count);
            if (error_count == 0)
            begin
                $display("test passed");
            end
            else
            begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

// ==== fetch_queue.f ====
+incdir+src
src/fetch_queue_pkg.sv
src/queue_read_if.sv
src/queue_storage.sv
src/queue_pointers.sv
src/dispatch_steer.sv
src/fetch_queue.sv
testbench/fetch_queue_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_queue

export_include_dirs:
  - src

sources:
  - files:
      - src/fetch_queue_pkg.sv
      - src/queue_read_if.sv
      - src/queue_storage.sv
      - src/queue_pointers.sv
      - src/dispatch_steer.sv
      - src/fetch_queue.sv

  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/fetch_queue_tb.sv

// ==== testbench/fetch_queue_stimulus.txt ====
# write word0 word1 word2 word3 busy, then expected after the edge: enables full empty
# masks in hex with bit 0 for decoder 1, word0 is the oldest; "test <name>" starts a test
test after_reset
0 00000000 00000000 00000000 00000000 f 0 0 1
0 00000000 00000000 00000000 00000000 0 0 0 1
test enqueue_then_drain
1 11110000 11110001 11110002 11110003 0 0 0 0
0 00000000 00000000 00000000 00000000 0 f 0 1
0 00000000 00000000 00000000 00000000 0 0 0 1
test partial_dispatch
1 22220000 22220001 22220002 22220003 a 0 0 0
0 00000000 00000000 00000000 00000000 a 5 0 0
0 00000000 00000000 00000000 00000000 e 1 0 0
0 00000000 00000000 00000000 00000000 0 1 0 1
test fewer_than_free
1 44440000 44440001 44440002 44440003 f 0 0 0
1 44440004 44440005 44440006 44440007 c 3 0 0
0 00000000 00000000 00000000 00000000 0 f 0 0
0 00000000 00000000 00000000 00000000 0 3 0 1
test full_and_refusal
1 55550000 55550001 55550002 55550003 f 0 0 0
1 55550004 55550005 55550006 55550007 f 0 0 0
1 55550008 55550009 5555000a 5555000b f 0 0 0
1 5555000c 5555000d 5555000e 5555000f f 0 1 0
1 dead0000 dead0001 dead0002 dead0003 f 0 1 0
0 00000000 00000000 00000000 00000000 0 f 0 0
0 00000000 00000000 00000000 00000000 0 f 0 0
0 00000000 00000000 00000000 00000000 0 f 0 0
0 00000000 00000000 00000000 00000000 0 f 0 1
test enqueue_dispatch_wrap
1 66660000 66660001 66660002 66660003 f 0 0 0
1 66660004 66660005 66660006 66660007 0 f 0 0
1 66660008 66660009 6666000a 6666000b 0 f 0 0
1 6666000c 6666000d 6666000e 6666000f 8 7 0 0
1 66660010 66660011 66660012 66660013 1 e 0 0
1 66660014 66660015 66660016 66660017 0 f 0 0
0 00000000 00000000 00000000 00000000 0 f 0 0
0 00000000 00000000 00000000 00000000 0 3 0 1
0 00000000 00000000 00000000 00000000 0 0 0 1
